// File: src/pu_cfg_pkg.sv
// Shared constants and types of the protection unit configuration block
package pu_cfg_pkg;

  // Significant AXI address bits, higher bits are not decoded
  localparam int unsigned ADDR_W = 7;
  // Bus and register data width
  localparam int unsigned DATA_W = 32;
  // One strobe per data byte
  localparam int unsigned STRB_W = DATA_W / 8;

  // Domains held in every policy register
  localparam int unsigned NUM_DOMAINS = 2;
  // Number of policy registers
  localparam int unsigned NUM_MEM_REGIONS = 4;
  // Index width for the policy registers
  localparam int unsigned REGION_IDX_W = 2;

  // Register map
  localparam logic [ADDR_W-1:0] CTRL_ADDR = 7'h00;
  localparam logic [ADDR_W-1:0] STATUS_ADDR = 7'h04;
  // Policy registers follow as consecutive words
  localparam logic [ADDR_W-1:0] POLICY_BASE_ADDR = 7'h40;

  // Access needs AxPROT[0] (privileged)
  localparam bit PRIV_PROT_ONLY = 1'b1;
  // Access needs AxPROT[1] when set
  localparam bit SECU_PROT_ONLY = 1'b0;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Marker returned with a refused read
  localparam logic [DATA_W-1:0] READ_ERR_DATA = 32'hBA5E_1E55;

  // Register selector codes from the address decode
  localparam logic [1:0] REG_SEL_CTRL = 2'd0;
  localparam logic [1:0] REG_SEL_STATUS = 2'd1;
  localparam logic [1:0] REG_SEL_POLICY = 2'd2;

  // Policy word, seen as a plain word, as bytes or as per-domain entries
  // Entry bit 1 is read permission, bit 0 is write permission
  typedef union packed {
    logic [DATA_W-1:0] word;
    logic [STRB_W-1:0][7:0] bytes;
    struct packed {
      // Upper bits carry no meaning and are forced to zero
      logic [DATA_W-2*NUM_DOMAINS-1:0] reserved;
      // Domain 0 sits in the lowest bits
      logic [NUM_DOMAINS-1:0][1:0] entry;
    } fields;
  } policy_word_u;

endpackage

// File: src/pu_cfg_decode.sv
`timescale 1ns/1ps

// Fixed address map and protection check for one address channel
module pu_cfg_decode (
  input  logic [pu_cfg_pkg::ADDR_W-1:0]       addr_i,
  input  logic [2:0]                          prot_i,
  output logic [1:0]                          sel_o,
  output logic [pu_cfg_pkg::REGION_IDX_W-1:0] region_o,
  output logic                                hit_o
);

  // Word address, the byte offset inside a word is ignored
  logic [pu_cfg_pkg::ADDR_W-3:0] word_addr;
  // Word range that holds the policy registers
  logic [pu_cfg_pkg::ADDR_W-3:0] pol_base;
  logic [pu_cfg_pkg::ADDR_W-3:0] pol_end;
  logic                          ctrl_hit;
  logic                          status_hit;
  logic                          policy_hit;
  logic                          prot_ok;

  assign word_addr = addr_i[pu_cfg_pkg::ADDR_W-1:2];
  assign pol_base  = pu_cfg_pkg::POLICY_BASE_ADDR[pu_cfg_pkg::ADDR_W-1:2];
  assign pol_end   = pol_base + (pu_cfg_pkg::ADDR_W-2)'(pu_cfg_pkg::NUM_MEM_REGIONS);

  assign ctrl_hit   = (word_addr == pu_cfg_pkg::CTRL_ADDR[pu_cfg_pkg::ADDR_W-1:2]);
  assign status_hit = (word_addr == pu_cfg_pkg::STATUS_ADDR[pu_cfg_pkg::ADDR_W-1:2]);
  assign policy_hit = (word_addr >= pol_base) && (word_addr < pol_end);

  // Base is aligned, so word address bits pick the region directly
  assign region_o = addr_i[2 +: pu_cfg_pkg::REGION_IDX_W];

  // Each enabled option demands its prot bit
  assign prot_ok = (pu_cfg_pkg::PRIV_PROT_ONLY ? prot_i[0] : 1'b1) &
                   (pu_cfg_pkg::SECU_PROT_ONLY ? prot_i[1] : 1'b1);

  // Selector is only meaningful together with hit_o
  always_comb
  begin
    sel_o = pu_cfg_pkg::REG_SEL_CTRL;
    if (status_hit)
    begin
      sel_o = pu_cfg_pkg::REG_SEL_STATUS;
    end
    else if (policy_hit)
    begin
      sel_o = pu_cfg_pkg::REG_SEL_POLICY;
    end
  end

  // Mapped and allowed by the protection options
  assign hit_o = (ctrl_hit | status_hit | policy_hit) & prot_ok;

endmodule

// File: src/pu_cfg_write_ctrl.sv
`timescale 1ns/1ps

// Write acceptance, joins AW and W and decides the B response
module pu_cfg_write_ctrl (
  input  logic                                                       clk_i,
  input  logic                                                       arst_n_i,
  input  logic                                                       aw_valid_i,
  input  logic                                                       w_valid_i,
  input  logic [pu_cfg_pkg::STRB_W-1:0]                              w_strb_i,
  input  logic [1:0]                                                 sel_i,
  input  logic [pu_cfg_pkg::REGION_IDX_W-1:0]                        region_i,
  input  logic                                                       hit_i,
  input  logic                                                       b_ready_i,
  output logic                                                       aw_ready_o,
  output logic                                                       w_ready_o,
  output logic                                                       b_valid_o,
  output logic [1:0]                                                 b_resp_o,
  output logic [pu_cfg_pkg::STRB_W-1:0]                              ctrl_upd_o,
  output logic [pu_cfg_pkg::NUM_MEM_REGIONS-1:0][pu_cfg_pkg::STRB_W-1:0] policy_upd_o
);

  logic        fire;
  logic        wr_ok;

  // Both channels present and a free slot in the B spill
  assign fire = aw_valid_i & w_valid_i & b_ready_i;

  // Status is read only, so only ctrl and policy take writes
  assign wr_ok = hit_i &
                 ((sel_i == pu_cfg_pkg::REG_SEL_CTRL) | (sel_i == pu_cfg_pkg::REG_SEL_POLICY));

  // AW and W complete together
  assign aw_ready_o = fire;
  assign w_ready_o  = fire;
  assign b_valid_o  = fire;
  assign b_resp_o   = wr_ok ? pu_cfg_pkg::RESP_OKAY : pu_cfg_pkg::RESP_SLVERR;

  // Route the strobes to the selected register only
  always_comb
  begin
    ctrl_upd_o   = '0;
    policy_upd_o = '0;
    if (fire && wr_ok)
    begin
      if (sel_i == pu_cfg_pkg::REG_SEL_CTRL)
      begin
        ctrl_upd_o = w_strb_i;
      end
      else
      begin
        policy_upd_o[region_i] = w_strb_i;
      end
    end
  end

endmodule

// File: src/pu_cfg_regfile.sv
`timescale 1ns/1ps

// Control and policy registers with byte updates and read mux
module pu_cfg_regfile (
  input  logic                                                       clk_i,
  input  logic                                                       arst_n_i,
  input  logic [pu_cfg_pkg::DATA_W-1:0]                              w_data_i,
  input  logic [pu_cfg_pkg::STRB_W-1:0]                              ctrl_upd_i,
  input  logic [pu_cfg_pkg::NUM_MEM_REGIONS-1:0][pu_cfg_pkg::STRB_W-1:0] policy_upd_i,
  input  logic [1:0]                                                 rd_sel_i,
  input  logic [pu_cfg_pkg::REGION_IDX_W-1:0]                        rd_region_i,
  input  logic                                                       rd_hit_i,
  output logic [pu_cfg_pkg::DATA_W-1:0]                              rd_data_o,
  output logic [1:0]                                                 rd_resp_o,
  output logic [pu_cfg_pkg::NUM_MEM_REGIONS-1:0][pu_cfg_pkg::NUM_DOMAINS-1:0][1:0] policy_o
);

  // Control register, kept as bytes for strobed writes
  logic [pu_cfg_pkg::STRB_W-1:0][7:0] ctrl_q;
  // Policy registers
  pu_cfg_pkg::policy_word_u [pu_cfg_pkg::NUM_MEM_REGIONS-1:0] policy_q;
  // Write data with the reserved field cleared
  pu_cfg_pkg::policy_word_u pol_wdata;
  logic [pu_cfg_pkg::STRB_W-1:0][7:0] w_bytes;

  assign w_bytes = w_data_i;

  always_comb
  begin
    pol_wdata.word = w_data_i;
    // Reserved bits never hold a one
    pol_wdata.fields.reserved = '0;
  end

  // Byte wise update, only strobed bytes change
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ctrl_q   <= '0;
      policy_q <= '0;
    end
    else
    begin
      for (int b = 0; b < pu_cfg_pkg::STRB_W; b++)
      begin
        if (ctrl_upd_i[b])
        begin
          ctrl_q[b] <= w_bytes[b];
        end
      end
      for (int r = 0; r < pu_cfg_pkg::NUM_MEM_REGIONS; r++)
      begin
        for (int b = 0; b < pu_cfg_pkg::STRB_W; b++)
        begin
          if (policy_upd_i[r][b])
          begin
            policy_q[r].bytes[b] <= pol_wdata.bytes[b];
          end
        end
      end
    end
  end

  // Read mux, a miss returns the error marker
  always_comb
  begin
    rd_data_o = pu_cfg_pkg::READ_ERR_DATA;
    rd_resp_o = pu_cfg_pkg::RESP_SLVERR;
    if (rd_hit_i)
    begin
      rd_resp_o = pu_cfg_pkg::RESP_OKAY;
      case (rd_sel_i)
        pu_cfg_pkg::REG_SEL_CTRL:
          rd_data_o = ctrl_q;
        pu_cfg_pkg::REG_SEL_STATUS:
          // No status sources yet
          rd_data_o = '0;
        pu_cfg_pkg::REG_SEL_POLICY:
          rd_data_o = policy_q[rd_region_i].word;
        default:
        begin
          rd_data_o = pu_cfg_pkg::READ_ERR_DATA;
          rd_resp_o = pu_cfg_pkg::RESP_SLVERR;
        end
      endcase
    end
  end

  // Policy entries out, region i at index i
  always_comb
  begin
    for (int r = 0; r < pu_cfg_pkg::NUM_MEM_REGIONS; r++)
    begin
      policy_o[r] = policy_q[r].fields.entry;
    end
  end

endmodule

// File: src/pu_cfg_spill.sv
`timescale 1ns/1ps

// Two entry spill register, all outputs come from flops
module pu_cfg_spill #(
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Head slot drives the outputs
  logic             head_full_q;
  logic [WIDTH-1:0] head_data_q;
  // Second slot catches data while the head is stalled
  logic             skid_full_q;
  logic [WIDTH-1:0] skid_data_q;

  logic accept;
  logic pop;
  // Head takes new data this cycle
  logic head_load;

  assign accept = valid_i & ready_o;
  assign pop    = head_full_q & ready_i;

  // Head is free or being emptied
  assign head_load = pop | ~head_full_q;

  // Space left while the second slot is empty
  assign ready_o = ~skid_full_q;
  assign valid_o = head_full_q;
  assign data_o  = head_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      head_full_q <= 1'b0;
      skid_full_q <= 1'b0;
    end
    else if (head_load)
    begin
      // Older entry in the second slot moves up first
      if (skid_full_q)
      begin
        head_full_q <= 1'b1;
        skid_full_q <= 1'b0;
      end
      else
      begin
        head_full_q <= accept;
      end
    end
    else if (accept)
    begin
      skid_full_q <= 1'b1;
    end
  end

  // Payload flops follow the same order as the flags
  always_ff @(posedge clk_i)
  begin
    if (head_load)
    begin
      if (skid_full_q)
      begin
        head_data_q <= skid_data_q;
      end
      else if (accept)
      begin
        head_data_q <= data_i;
      end
    end
    else if (accept)
    begin
      skid_data_q <= data_i;
    end
  end

endmodule

// File: src/pu_cfg_top.sv
`timescale 1ns/1ps

// AXI4-Lite configuration block of the memory protection unit
module pu_cfg_top (
  input  logic                                                       clk_i,
  input  logic                                                       arst_n_i,
  // Write address
  input  logic                                                       aw_valid_i,
  output logic                                                       aw_ready_o,
  input  logic [pu_cfg_pkg::ADDR_W-1:0]                              aw_addr_i,
  input  logic [2:0]                                                 aw_prot_i,
  // Write data
  input  logic                                                       w_valid_i,
  output logic                                                       w_ready_o,
  input  logic [pu_cfg_pkg::DATA_W-1:0]                              w_data_i,
  input  logic [pu_cfg_pkg::STRB_W-1:0]                              w_strb_i,
  // Write response
  output logic                                                       b_valid_o,
  input  logic                                                       b_ready_i,
  output logic [1:0]                                                 b_resp_o,
  // Read address
  input  logic                                                       ar_valid_i,
  output logic                                                       ar_ready_o,
  input  logic [pu_cfg_pkg::ADDR_W-1:0]                              ar_addr_i,
  input  logic [2:0]                                                 ar_prot_i,
  // Read data
  output logic                                                       r_valid_o,
  input  logic                                                       r_ready_i,
  output logic [pu_cfg_pkg::DATA_W-1:0]                              r_data_o,
  output logic [1:0]                                                 r_resp_o,
  // Configured permissions per region and domain
  output logic [pu_cfg_pkg::NUM_MEM_REGIONS-1:0][pu_cfg_pkg::NUM_DOMAINS-1:0][1:0] policy_o
);

  // Write path decode
  logic [1:0]                          aw_sel;
  logic [pu_cfg_pkg::REGION_IDX_W-1:0] aw_region;
  logic                                aw_hit;
  // Read path decode
  logic [1:0]                          ar_sel;
  logic [pu_cfg_pkg::REGION_IDX_W-1:0] ar_region;
  logic                                ar_hit;

  // B channel into its spill
  logic                                b_valid;
  logic                                b_ready;
  logic [1:0]                          b_resp;

  // Byte update strobes
  logic [pu_cfg_pkg::STRB_W-1:0]                              ctrl_upd;
  logic [pu_cfg_pkg::NUM_MEM_REGIONS-1:0][pu_cfg_pkg::STRB_W-1:0] policy_upd;

  // Read mux result, sampled by the R spill
  logic [pu_cfg_pkg::DATA_W-1:0]       rd_data;
  logic [1:0]                          rd_resp;

  pu_cfg_decode dec_aw (
    .addr_i   (aw_addr_i),
    .prot_i   (aw_prot_i),
    .sel_o    (aw_sel),
    .region_o (aw_region),
    .hit_o    (aw_hit)
  );

  pu_cfg_decode dec_ar (
    .addr_i   (ar_addr_i),
    .prot_i   (ar_prot_i),
    .sel_o    (ar_sel),
    .region_o (ar_region),
    .hit_o    (ar_hit)
  );

  pu_cfg_write_ctrl wctl0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .aw_valid_i   (aw_valid_i),
    .w_valid_i    (w_valid_i),
    .w_strb_i     (w_strb_i),
    .sel_i        (aw_sel),
    .region_i     (aw_region),
    .hit_i        (aw_hit),
    .b_ready_i    (b_ready),
    .aw_ready_o   (aw_ready_o),
    .w_ready_o    (w_ready_o),
    .b_valid_o    (b_valid),
    .b_resp_o     (b_resp),
    .ctrl_upd_o   (ctrl_upd),
    .policy_upd_o (policy_upd)
  );

  pu_cfg_regfile regs0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .w_data_i     (w_data_i),
    .ctrl_upd_i   (ctrl_upd),
    .policy_upd_i (policy_upd),
    .rd_sel_i     (ar_sel),
    .rd_region_i  (ar_region),
    .rd_hit_i     (ar_hit),
    .rd_data_o    (rd_data),
    .rd_resp_o    (rd_resp),
    .policy_o     (policy_o)
  );

  // Cuts the path from AW and W to B
  pu_cfg_spill #(
    .WIDTH (2)
  ) spill_b (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (b_valid),
    .ready_o  (b_ready),
    .data_i   (b_resp),
    .valid_o  (b_valid_o),
    .ready_i  (b_ready_i),
    .data_o   (b_resp_o)
  );

  // Read is accepted whenever the R spill has room
  pu_cfg_spill #(
    .WIDTH (pu_cfg_pkg::DATA_W + 2)
  ) spill_r (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (ar_valid_i),
    .ready_o  (ar_ready_o),
    .data_i   ({rd_resp, rd_data}),
    .valid_o  (r_valid_o),
    .ready_i  (r_ready_i),
    .data_o   ({r_resp_o, r_data_o})
  );

endmodule

// File: sim/pu_cfg_chk.sv
`timescale 1ns/1ps

// Handshake rules on the response channels of pu_cfg_top
module pu_cfg_chk (
  input logic                          clk_i,
  input logic                          arst_n_i,
  input logic                          aw_ready_o,
  input logic                          w_ready_o,
  input logic                          b_valid_o,
  input logic                          b_ready_i,
  input logic [1:0]                    b_resp_o,
  input logic                          r_valid_o,
  input logic                          r_ready_i,
  input logic [pu_cfg_pkg::DATA_W-1:0] r_data_o,
  input logic [1:0]                    r_resp_o
);

  // A stalled B response keeps its code
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else $error("B response changed while stalled");

  // A stalled R response keeps data and code
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else $error("R response changed while stalled");

  // AW and W complete together
  assert property (@(posedge clk_i) aw_ready_o == w_ready_o)
    else $error("aw_ready_o and w_ready_o differ");

  assert property (@(posedge clk_i) !arst_n_i |-> !b_valid_o && !r_valid_o)
    else $error("Response valid during reset");

endmodule

bind pu_cfg_top pu_cfg_chk chk0 (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .aw_ready_o (aw_ready_o),
  .w_ready_o  (w_ready_o),
  .b_valid_o  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_resp_o   (b_resp_o),
  .r_valid_o  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_data_o   (r_data_o),
  .r_resp_o   (r_resp_o)
);

// File: sim/pu_cfg_tb.sv
`timescale 1ns/1ps

module pu_cfg_tb;

  localparam int NUM_ENTRIES = 33;
  // Generous bound on the whole run, reset included
  localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 100;

  localparam logic WR = 1'b1;
  localparam logic RD = 1'b0;
  localparam logic [1:0] OK = 2'b00;
  localparam logic [1:0] ERR = 2'b10;
  // Privileged and unprivileged prot values
  localparam logic [2:0] PRV = 3'b001;
  localparam logic [2:0] USR = 3'b000;

  logic                              clk_i;
  logic                              arst_n_i;
  logic                              aw_valid_i;
  logic                              aw_ready_o;
  logic [pu_cfg_pkg::ADDR_W-1:0]     aw_addr_i;
  logic [2:0]                        aw_prot_i;
  logic                              w_valid_i;
  logic                              w_ready_o;
  logic [pu_cfg_pkg::DATA_W-1:0]     w_data_i;
  logic [pu_cfg_pkg::STRB_W-1:0]     w_strb_i;
  logic                              b_valid_o;
  logic                              b_ready_i;
  logic [1:0]                        b_resp_o;
  logic                              ar_valid_i;
  logic                              ar_ready_o;
  logic [pu_cfg_pkg::ADDR_W-1:0]     ar_addr_i;
  logic [2:0]                        ar_prot_i;
  logic                              r_valid_o;
  logic                              r_ready_i;
  logic [pu_cfg_pkg::DATA_W-1:0]     r_data_o;
  logic [1:0]                        r_resp_o;
  logic [15:0]                       policy_o;

  // Stimulus table, last column is read data or policy_o after a write
  logic        t_write [NUM_ENTRIES];
  logic [6:0]  t_addr [NUM_ENTRIES];
  logic [31:0] t_data [NUM_ENTRIES];
  logic [3:0]  t_strb [NUM_ENTRIES];
  logic [2:0]  t_prot [NUM_ENTRIES];
  logic [1:0]  t_resp [NUM_ENTRIES];
  logic [31:0] t_exp [NUM_ENTRIES];
  int          n_added;

  // Register model
  logic [31:0] ctrl_m;
  logic [31:0] pol_m [4];

  // Responses still owed by the DUT, in issue order
  logic [1:0]  b_exp_q [$];
  logic [33:0] r_exp_q [$];
  int          n_writes;
  int          n_reads;
  int          b_seen;
  int          r_seen;
  int          err_cnt;
  int          cycle_cnt;
  int          idx;
  integer      seed;
  logic [31:0] rnd;
  logic [1:0]  exp_b;
  logic [33:0] exp_r;

  pu_cfg_top dut0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_prot_i  (aw_prot_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_prot_i  (ar_prot_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .policy_o   (policy_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    begin
      if (got !== exp)
      begin
        err_cnt++;
        $display("Fail %s: got %h, expected %h", name, got, exp);
        $display("Testbench failed");
        $fatal(1, "stopped at first mismatch");
      end
    end
  endtask

  task add_entry(input logic wr, input logic [6:0] addr, input logic [31:0] data,
                 input logic [3:0] strb, input logic [2:0] prot, input logic [1:0] resp,
                 input logic [31:0] exp);
    begin
      t_write[n_added] = wr;
      t_addr[n_added]  = addr;
      t_data[n_added]  = data;
      t_strb[n_added]  = strb;
      t_prot[n_added]  = prot;
      t_resp[n_added]  = resp;
      t_exp[n_added]   = exp;
      n_added++;
    end
  endtask

  task load_table;
    begin
      // Reset values
      add_entry(RD, 7'h00, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h04, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h40, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h44, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h48, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h4C, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      // Byte merges on ctrl
      add_entry(WR, 7'h00, 32'h1122_3344, 4'hF, PRV, OK, 32'h0000_0000);
      add_entry(WR, 7'h00, 32'hAABB_CCDD, 4'h5, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h00, 32'h0, 4'h0, PRV, OK, 32'h11BB_33DD);
      add_entry(WR, 7'h00, 32'hEEEE_EEEE, 4'h8, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h00, 32'h0, 4'h0, PRV, OK, 32'hEEBB_33DD);
      // Policy entries, reserved bits masked
      add_entry(WR, 7'h40, 32'hFFFF_FFFF, 4'hF, PRV, OK, 32'h0000_000F);
      add_entry(RD, 7'h40, 32'h0, 4'h0, PRV, OK, 32'h0000_000F);
      add_entry(WR, 7'h48, 32'hFFFF_FFF6, 4'hF, PRV, OK, 32'h0000_060F);
      add_entry(RD, 7'h48, 32'h0, 4'h0, PRV, OK, 32'h0000_0006);
      add_entry(WR, 7'h4C, 32'h0000_0009, 4'h1, PRV, OK, 32'h0000_960F);
      // Byte 0 not strobed, entries stay
      add_entry(WR, 7'h44, 32'hFFFF_FF03, 4'hE, PRV, OK, 32'h0000_960F);
      add_entry(RD, 7'h44, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(RD, 7'h4C, 32'h0, 4'h0, PRV, OK, 32'h0000_0009);
      // Refused writes and reads
      add_entry(WR, 7'h04, 32'hFFFF_FFFF, 4'hF, PRV, ERR, 32'h0000_960F);
      add_entry(RD, 7'h04, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
      add_entry(WR, 7'h20, 32'h1234_5678, 4'hF, PRV, ERR, 32'h0000_960F);
      add_entry(WR, 7'h00, 32'h0000_0000, 4'hF, USR, ERR, 32'h0000_960F);
      add_entry(RD, 7'h00, 32'h0, 4'h0, PRV, OK, 32'hEEBB_33DD);
      add_entry(RD, 7'h20, 32'h0, 4'h0, PRV, ERR, 32'hBA5E_1E55);
      add_entry(RD, 7'h00, 32'h0, 4'h0, USR, ERR, 32'hBA5E_1E55);
      add_entry(WR, 7'h50, 32'hFFFF_FFFF, 4'hF, PRV, ERR, 32'h0000_960F);
      add_entry(RD, 7'h50, 32'h0, 4'h0, PRV, ERR, 32'hBA5E_1E55);
      // Extra prot bits do not matter, nor do the low address bits
      add_entry(WR, 7'h44, 32'h0000_000A, 4'h1, 3'b111, OK, 32'h0000_96AF);
      add_entry(RD, 7'h44, 32'h0, 4'h0, 3'b011, OK, 32'h0000_000A);
      add_entry(RD, 7'h4E, 32'h0, 4'h0, PRV, OK, 32'h0000_0009);
      add_entry(WR, 7'h00, 32'h0000_0000, 4'hF, PRV, OK, 32'h0000_96AF);
      add_entry(RD, 7'h00, 32'h0, 4'h0, PRV, OK, 32'h0000_0000);
    end
  endtask

  // Expected response from the register map rules, updates the model on writes
  task model_access(input int i, output logic [1:0] resp, output logic [31:0] data);
    logic [4:0]  word;
    logic        is_ctrl;
    logic        is_status;
    logic        is_pol;
    logic [31:0] merged;
    int          r;
    int          b;
    begin
      word      = t_addr[i][6:2];
      is_ctrl   = (word == 5'h00);
      is_status = (word == 5'h01);
      is_pol    = (word >= 5'h10) && (word <= 5'h13);
      r         = int'(word[1:0]);
      if (t_write[i])
      begin
        resp = ERR;
        if (t_prot[i][0] && (is_ctrl || is_pol))
        begin
          resp   = OK;
          merged = is_ctrl ? ctrl_m : pol_m[r];
          for (b = 0; b < 4; b++)
          begin
            if (t_strb[i][b])
            begin
              merged[8*b +: 8] = t_data[i][8*b +: 8];
            end
          end
          if (is_ctrl)
          begin
            ctrl_m = merged;
          end
          else
          begin
            pol_m[r] = merged & 32'h0000_000F;
          end
        end
        // Domain 0 of region 0 in the lowest bits
        data = {16'h0, pol_m[3][3:0], pol_m[2][3:0], pol_m[1][3:0], pol_m[0][3:0]};
      end
      else if (t_prot[i][0] && (is_ctrl || is_status || is_pol))
      begin
        resp = OK;
        data = is_ctrl ? ctrl_m : (is_pol ? pol_m[r] : 32'h0);
      end
      else
      begin
        resp = ERR;
        data = 32'hBA5E_1E55;
      end
    end
  endtask

  // Issue one entry and wait for its address handshake
  task run_entry(input int i);
    logic [1:0]  m_resp;
    logic [31:0] m_data;
    logic        taken;
    begin
      model_access(i, m_resp, m_data);
      check_value("t_resp", {30'h0, t_resp[i]}, {30'h0, m_resp});
      check_value("t_exp", t_exp[i], m_data);
      taken = 1'b0;
      if (t_write[i])
      begin
        b_exp_q.push_back(m_resp);
        n_writes++;
        aw_valid_i = 1'b1;
        aw_addr_i  = t_addr[i];
        aw_prot_i  = t_prot[i];
        w_valid_i  = 1'b1;
        w_data_i   = t_data[i];
        w_strb_i   = t_strb[i];
        while (!taken)
        begin
          // Ready is settled a moment after the falling edge
          #1;
          taken = aw_ready_o;
          @(negedge clk_i);
        end
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
        check_value("policy_o", {16'h0, policy_o}, t_exp[i]);
      end
      else
      begin
        r_exp_q.push_back({m_resp, m_data});
        n_reads++;
        ar_valid_i = 1'b1;
        ar_addr_i  = t_addr[i];
        ar_prot_i  = t_prot[i];
        while (!taken)
        begin
          #1;
          taken = ar_ready_o;
          @(negedge clk_i);
        end
        ar_valid_i = 1'b0;
      end
    end
  endtask

  // Random ready gaps and in order response checks
  initial
  begin
    forever
    begin
      @(negedge clk_i);
      rnd = $random(seed);
      b_ready_i = (rnd[1:0] != 2'b00);
      r_ready_i = (rnd[3:2] != 2'b00);
      #1;
      if (b_valid_o && b_ready_i)
      begin
        if (b_exp_q.size() == 0)
        begin
          $display("B response arrived with no write outstanding");
          $display("Testbench failed");
          $fatal(1, "extra write response");
        end
        else
        begin
          exp_b = b_exp_q.pop_front();
          check_value("b_resp_o", {30'h0, b_resp_o}, {30'h0, exp_b});
          b_seen++;
        end
      end
      if (r_valid_o && r_ready_i)
      begin
        if (r_exp_q.size() == 0)
        begin
          $display("R response arrived with no read outstanding");
          $display("Testbench failed");
          $fatal(1, "extra read response");
        end
        else
        begin
          exp_r = r_exp_q.pop_front();
          check_value("r_resp_o", {30'h0, r_resp_o}, {30'h0, exp_r[33:32]});
          check_value("r_data_o", r_data_o, exp_r[31:0]);
          r_seen++;
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: responses still missing after %0d cycles", cycle_cnt);
      $display("Testbench failed");
      $fatal(1, "run did not complete");
    end
  end

  initial
  begin
    seed       = 32'h490f_0148;
    arst_n_i   = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_prot_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_prot_i  = '0;
    r_ready_i  = 1'b0;
    ctrl_m     = '0;
    for (idx = 0; idx < 4; idx++)
    begin
      pol_m[idx] = '0;
    end
    n_added   = 0;
    n_writes  = 0;
    n_reads   = 0;
    b_seen    = 0;
    r_seen    = 0;
    err_cnt   = 0;
    cycle_cnt = 0;
    load_table();
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("policy_o", {16'h0, policy_o}, 32'h0);
    // Back to back issue, responses drain on their own
    for (idx = 0; idx < NUM_ENTRIES; idx++)
    begin
      run_entry(idx);
    end
    wait ((b_seen == n_writes) && (r_seen == n_reads));
    // Room for a duplicate response to show up
    repeat (8) @(negedge clk_i);
    if (err_cnt == 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      $display("Testbench failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: compile.f
src/pu_cfg_pkg.sv
src/pu_cfg_decode.sv
src/pu_cfg_write_ctrl.sv
src/pu_cfg_regfile.sv
src/pu_cfg_spill.sv
src/pu_cfg_top.sv
sim/pu_cfg_chk.sv
sim/pu_cfg_tb.sv

// File: Makefile
TOP := pu_cfg_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
